// File: Bender.yml
package:
  name: random_panel

sources:
  # packages before the modules that import them
  - hw/rng_pkg.sv
  - hw/seg_pkg.sv
  - hw/panel_input.sv
  - hw/lfsr_core.sv
  - hw/display_driver.sv
  - hw/random_panel.sv

  - target: simulation
    files:
      - dv/random_panel_assertions.sv
      - dv/random_panel_tb.sv

// File: dv/random_panel_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module random_panel_assertions (
    input  wire logic                  btn,
    input  wire logic                  rst_n,
    input  wire logic [15:0]           sw,
    input  wire seg_pkg::seg_pattern_t seg0,
    input  wire seg_pkg::seg_pattern_t seg1,
    input  wire logic [15:0]           ledr
);

    // failures so far, read by the testbench after each phase
    int unsigned fail_count = 0;

    // active-low {a..g, dp} for the digits 0 to F
    localparam logic [7:0] digit_table [16] = '{
        8'h03, 8'h9f, 8'h25, 8'h0d, 8'h99, 8'h49, 8'h41, 8'h1f,
        8'h01, 8'h09, 8'h11, 8'hc1, 8'h63, 8'h85, 8'h61, 8'h71
    };

    // sw_d1/sw_d2 mirror the two synchronizer stages
    // sw_d3 is the control that produced the state now in the core
    logic [9:0] sw_d1;
    logic [9:0] sw_d2;
    logic [9:0] sw_d3;
    logic       started;
    logic [7:0] led_now;

    assign led_now = ledr[7:0];

    // shift right, feedback from bits 4, 3, 2 and 0 into the top
    function automatic logic [7:0] next_value(input logic [7:0] cur);
        logic fb;
        fb = cur[4] ^ cur[3] ^ cur[2] ^ cur[0];
        if (cur == 8'h00) begin
            return 8'h01;
        end else begin
            return {fb, cur[7:1]};
        end
    endfunction

    task automatic count_failure(input string what);
        $error("%s", what);
        fail_count = fail_count + 1;
    endtask

    always_ff @(posedge btn or negedge rst_n) begin
        if (!rst_n) begin
            sw_d1 <= '0;
            sw_d2 <= '0;
            sw_d3 <= '0;
        end else begin
            sw_d1 <= sw[9:0];
            sw_d2 <= sw_d1;
            sw_d3 <= sw_d2;
        end
    end

    // display shows the state from here on
    always_ff @(posedge btn or negedge rst_n) begin
        if (!rst_n) begin
            started <= 1'b0;
        end else begin
            started <= 1'b1;
        end
    end

    reset_dark: assert property (@(posedge btn)
        !started |-> (ledr == 16'h0000 && seg0 == 8'hff && seg1 == 8'hff))
        else count_failure("outputs not dark before the first edge after reset");

    first_value: assert property (@(posedge btn) disable iff (!rst_n)
        $rose(started) |-> led_now == 8'h01)
        else count_failure("first value after reset is not 8'h01");

    free_step: assert property (@(posedge btn) disable iff (!rst_n)
        started && sw_d3[9:8] == 2'b00 |=> led_now == next_value($past(led_now)))
        else count_failure("ledr did not follow the step rule");

    hold_keeps: assert property (@(posedge btn) disable iff (!rst_n)
        started && sw_d3[9] && !sw_d3[8] |=> led_now == $past(led_now))
        else count_failure("ledr changed while hold was set");

    load_takes: assert property (@(posedge btn) disable iff (!rst_n)
        started && sw_d3[8] |=> led_now == $past(sw_d3[7:0]))
        else count_failure("ledr does not show the loaded seed");

    zero_recovers: assert property (@(posedge btn) disable iff (!rst_n)
        started && sw_d3[9:8] == 2'b00 && led_now == 8'h00 |=> led_now == 8'h01)
        else count_failure("zero state did not recover to 8'h01");

    digits_match: assert property (@(posedge btn) disable iff (!rst_n)
        started |-> (seg0 == digit_table[ledr[3:0]] && seg1 == digit_table[ledr[7:4]]
                     && ledr[15:8] == 8'h00))
        else count_failure("digits or upper leds do not match ledr");

endmodule : random_panel_assertions

`default_nettype wire

// File: dv/random_panel_tb.sv
`timescale 1ns/10ps
`default_nettype none

module random_panel_tb;

    import seg_pkg::*;

    localparam int half_period = 10;
    // phases take about 570 edges
    localparam int cycle_limit = 1200;

    logic         btn;
    logic         rst_n;
    logic [15:0]  sw;
    seg_pattern_t seg0;
    seg_pattern_t seg1;
    logic [15:0]  ledr;

    int unsigned  cycle_count = 0;
    int unsigned  fails_seen = 0;
    int           tests_passed = 0;
    int           tests_failed = 0;

    random_panel UUT (
        .btn   (btn),
        .rst_n (rst_n),
        .sw    (sw),
        .seg0  (seg0),
        .seg1  (seg1),
        .ledr  (ledr)
    );

    bind random_panel random_panel_assertions u_checks (
        .btn   (btn),
        .rst_n (rst_n),
        .sw    (sw),
        .seg0  (seg0),
        .seg1  (seg1),
        .ledr  (ledr)
    );

    initial btn = 1'b0;
    always #(half_period) btn = ~btn;

    // returns 2 ns after the last edge, where inputs change
    task automatic run_edges(input int n);
        repeat (n) @(posedge btn);
        #2;
    endtask

    task automatic close_test(input string name);
        int unsigned now_fails;
        now_fails = UUT.u_checks.fail_count;
        if (now_fails == fails_seen) begin
            $display("[PASS] %s", name);
            tests_passed++;
        end else begin
            $display("[FAIL] %0d ns: %s, %0d assertion failures", $time, name,
                     now_fails - fails_seen);
            tests_failed++;
        end
        fails_seen = now_fails;
    endtask

    task automatic load_seed(input logic [7:0] seed, input int edges);
        sw = {6'b0, 1'b0, 1'b1, seed};
        run_edges(edges);
    endtask

    initial begin
        void'($urandom(26240));
        rst_n = 1'b1;
        sw = 16'h0000;
        #1;
        rst_n = 1'b0;
        run_edges(5);
        rst_n = 1'b1;
        run_edges(4);
        close_test("reset");

        run_edges(300);
        close_test("free run");

        sw[9] = 1'b1;
        run_edges(20);
        sw[9] = 1'b0;
        run_edges(20);
        close_test("hold");

        for (int i = 0; i < 8; i++) begin
            load_seed(8'($urandom), 8);
            sw[8] = 1'b0;
            run_edges(6);
        end
        close_test("load");

        load_seed(8'h00, 8);
        sw[8] = 1'b0;
        run_edges(10);
        close_test("zero recovery");

        // every pattern on both digits
        for (int k = 0; k < 16; k++) begin
            load_seed({4'(k), 4'(15 - k)}, 5);
        end
        sw = 16'h0000;
        run_edges(10);
        close_test("display");

        $display("tests: %0d passed, %0d failed, %0d assertion failures",
                 tests_passed, tests_failed, fails_seen);
        if (tests_failed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        while (cycle_count < cycle_limit) begin
            @(posedge btn);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule : random_panel_tb

`default_nettype wire

// File: hw/display_driver.sv
`timescale 1ns/10ps
`default_nettype none

module display_driver (
    input  wire logic               btn,
    input  wire logic               rst_n,
    input  wire rng_pkg::rng_state_t state,
    output seg_pkg::seg_pattern_t   seg0,
    output seg_pkg::seg_pattern_t   seg1,
    output logic [15:0]             ledr
);

    import rng_pkg::*;
    import seg_pkg::*;

    nibble_t      nib_lo;
    nibble_t      nib_hi;
    seg_pattern_t pat_lo;
    seg_pattern_t pat_hi;

    seg_pattern_t seg0_q;
    seg_pattern_t seg1_q;
    rng_state_t   led_q;

    assign nib_lo = state[3:0];
    assign nib_hi = state[7:4];

    assign pat_lo = hex_to_seg(nib_lo);
    assign pat_hi = hex_to_seg(nib_hi);

    // digits come up blank until the first edge
    always_ff @(posedge btn or negedge rst_n) begin
        if (!rst_n) begin
            seg0_q <= seg_blank;
            seg1_q <= seg_blank;
        end else begin
            seg0_q <= pat_lo;
            seg1_q <= pat_hi;
        end
    end

    always_ff @(posedge btn or negedge rst_n) begin
        if (!rst_n) begin
            led_q <= '0;
        end else begin
            led_q <= state;
        end
    end

    assign seg0 = seg0_q;
    assign seg1 = seg1_q;

    // upper leds unused on this panel
    assign ledr = {8'h00, led_q};

endmodule : display_driver

`default_nettype wire

// File: hw/lfsr_core.sv
`timescale 1ns/10ps
`default_nettype none

module lfsr_core (
    input  wire logic               btn,
    input  wire logic               rst_n,
    input  wire rng_pkg::panel_ctrl_t ctrl,
    output rng_pkg::rng_state_t     state
);

    import rng_pkg::*;

    rng_state_t state_q;
    rng_state_t state_d;
    rng_state_t stepped;
    logic       feedback;
    logic       is_zero;

    assign feedback = ^(state_q & rng_tap_mask);
    assign stepped  = {feedback, state_q[7:1]};
    assign is_zero  = (state_q == '0);

    // load wins over hold, hold wins over stepping
    always_comb begin
        if (ctrl.load) begin
            // taken as is, zero included
            state_d = rng_state_t'(ctrl.seed);
        end else if (ctrl.hold) begin
            state_d = state_q;
        end else if (is_zero) begin
            state_d = rng_init_value;
        end else begin
            state_d = stepped;
        end
    end

    always_ff @(posedge btn or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= rng_init_value;
        end else begin
            state_q <= state_d;
        end
    end

    assign state = state_q;

endmodule : lfsr_core

`default_nettype wire

// File: hw/panel_input.sv
`timescale 1ns/10ps
`default_nettype none

module panel_input (
    input  wire logic               btn,
    input  wire logic               rst_n,
    input  wire logic [15:0]        sw,
    output rng_pkg::panel_ctrl_t    ctrl
);

    import rng_pkg::*;

    // sw[15:10] belong to other experiments on the board
    logic [9:0] sw_used;

    // first stage, may go metastable
    logic [9:0] sw_meta;

    // second stage before packing
    logic [9:0] sw_sync;

    assign sw_used = sw[9:0];

    always_ff @(posedge btn or negedge rst_n) begin
        if (!rst_n) begin
            sw_meta <= '0;
        end else begin
            sw_meta <= sw_used;
        end
    end

    always_ff @(posedge btn or negedge rst_n) begin
        if (!rst_n) begin
            sw_sync <= '0;
        end else begin
            sw_sync <= sw_meta;
        end
    end

    // sw[9] hold, sw[8] load, sw[7:0] seed
    always_comb begin
        ctrl      = panel_ctrl_idle;
        ctrl.seed = rng_seed_t'(sw_sync[7:0]);
        ctrl.load = sw_sync[8];
        ctrl.hold = sw_sync[9];
    end

endmodule : panel_input

`default_nettype wire

// File: hw/random_panel.sv
`timescale 1ns/10ps
`default_nettype none

module random_panel (
    input  wire logic               btn,
    input  wire logic               rst_n,
    input  wire logic [15:0]        sw,
    output seg_pkg::seg_pattern_t   seg0,
    output seg_pkg::seg_pattern_t   seg1,
    output logic [15:0]             ledr
);

    import rng_pkg::*;

    // synchronized switches
    panel_ctrl_t ctrl;

    // current register value
    rng_state_t  state;

    // btn clocks the whole panel, there is no other clock
    panel_input u_input (
        .btn   (btn),
        .rst_n (rst_n),
        .sw    (sw),
        .ctrl  (ctrl)
    );

    lfsr_core u_core (
        .btn   (btn),
        .rst_n (rst_n),
        .ctrl  (ctrl),
        .state (state)
    );

    // one edge behind the core
    display_driver u_display (
        .btn   (btn),
        .rst_n (rst_n),
        .state (state),
        .seg0  (seg0),
        .seg1  (seg1),
        .ledr  (ledr)
    );

endmodule : random_panel

`default_nettype wire

// File: hw/rng_pkg.sv
`default_nettype none

package rng_pkg;

    // step rule of the panel register, applied on every btn edge
    //   next = {s[4] ^ s[3] ^ s[2] ^ s[0], s[7:1]}
    // the register shifts right by one and the feedback enters at the top
    // an all-zero state cannot step, so it is replaced by 8'h01 instead

    // register contents
    typedef logic [7:0] rng_state_t;

    // seed as read from sw[7:0]
    typedef logic [7:0] rng_seed_t;

    // bits of the state that feed the xor
    localparam rng_state_t rng_tap_mask = 8'b0001_1101;

    // value after reset and after zero recovery
    localparam rng_state_t rng_init_value = 8'h01;

    // switches after synchronization, same order as sw[9:0]
    // hold sits in the msb, seed in the low byte
    typedef struct packed {
        logic      hold;
        logic      load;
        rng_seed_t seed;
    } panel_ctrl_t;

    // all switches off
    localparam panel_ctrl_t panel_ctrl_idle = '{hold: 1'b0, load: 1'b0, seed: '0};

endpackage : rng_pkg

`default_nettype wire

// File: hw/seg_pkg.sv
`default_nettype none

package seg_pkg;

    // one digit, active low, bit order {a, b, c, d, e, f, g, dp}
    typedef logic [7:0] seg_pattern_t;

    // the seven segments alone, active high, {a, b, c, d, e, f, g}
    typedef logic [6:0] seg_lit_t;

    // one hex digit
    typedef logic [3:0] nibble_t;

    // every segment and the point dark
    localparam seg_pattern_t seg_blank = 8'hff;

    function automatic seg_pattern_t hex_to_seg(input nibble_t value);
        seg_lit_t lit;
        case (value)
            4'h0: lit = 7'b111_1110;
            4'h1: lit = 7'b011_0000;
            4'h2: lit = 7'b110_1101;
            4'h3: lit = 7'b111_1001;
            4'h4: lit = 7'b011_0011;
            4'h5: lit = 7'b101_1011;
            4'h6: lit = 7'b101_1111;
            4'h7: lit = 7'b111_0000;
            4'h8: lit = 7'b111_1111;
            4'h9: lit = 7'b111_1011;
            // letters A b C d E F, b and d in lower case
            4'ha: lit = 7'b111_0111;
            4'hb: lit = 7'b001_1111;
            4'hc: lit = 7'b100_1110;
            4'hd: lit = 7'b011_1101;
            4'he: lit = 7'b100_1111;
            default: lit = 7'b100_0111;
        endcase
        // invert for the common-anode digits, point stays off
        return {~lit, 1'b1};
    endfunction

endpackage : seg_pkg

`default_nettype wire

// File: random_panel.f
hw/rng_pkg.sv
hw/seg_pkg.sv
hw/panel_input.sv
hw/lfsr_core.sv
hw/display_driver.sv
hw/random_panel.sv
dv/random_panel_assertions.sv
dv/random_panel_tb.sv
